//--- logic/fu_consts.svh
`ifndef FU_CONSTS_SVH
`define FU_CONSTS_SVH

// datapath word width
`define FU_XLEN 64

// low half of a word for the *w instructions
`define FU_HALF_XLEN 32

// shift amount bits for full and half words
`define FU_SHAMT_WIDTH 6
`define FU_HALF_SHAMT_WIDTH 5

// program counter width
`define FU_PC_WIDTH 32

// raw immediate as delivered by decode
`define FU_IMM_LEN 32

// rename tags
`define FU_ROB_INDEX_WIDTH 4
`define FU_PRD_ADDR_WIDTH 6

// encoding widths of the select and function fields
`define FU_OPR_SEL_WIDTH 2
`define FU_FUNC3_WIDTH 3

`endif

//--- logic/fu_pkg.sv
`include "fu_consts.svh"

package fu_pkg;

    typedef logic [`FU_XLEN-1:0]            xlen_t;
    typedef logic [`FU_PC_WIDTH-1:0]        pc_t;
    typedef logic [`FU_IMM_LEN-1:0]         imm_t;
    typedef logic [`FU_ROB_INDEX_WIDTH-1:0] rob_index_t;
    typedef logic [`FU_PRD_ADDR_WIDTH-1:0]  prd_addr_t;

    // operand source where 3 is never issued
    typedef enum logic [`FU_OPR_SEL_WIDTH-1:0] {
        OPR_SEL_REG = 2'd0,
        OPR_SEL_IMM = 2'd1,
        OPR_SEL_PC  = 2'd2
    } opr_sel_e;

    // riscv func3 codes of the op/op-imm group
    typedef enum logic [`FU_FUNC3_WIDTH-1:0] {
        ALU_ADD_SUB = 3'd0,
        ALU_SLL     = 3'd1,
        ALU_SLT     = 3'd2,
        ALU_SLTU    = 3'd3,
        ALU_XOR     = 3'd4,
        ALU_SRL_SRA = 3'd5,
        ALU_OR      = 3'd6,
        ALU_AND     = 3'd7
    } alu_func_e;

    // branch func3 codes
    typedef enum logic [`FU_FUNC3_WIDTH-1:0] {
        BR_BEQ  = 3'd0,
        BR_BNE  = 3'd1,
        BR_BLT  = 3'd4,
        BR_BGE  = 3'd5,
        BR_BLTU = 3'd6,
        BR_BGEU = 3'd7
    } br_func_e;

endpackage

//--- logic/fu_opr_select.sv
`include "fu_consts.svh"

module fu_opr_select
    import fu_pkg::*;
(
    input  logic                       req_valid_i,
    input  xlen_t                      rs1_i,
    input  xlen_t                      rs2_i,
    input  imm_t                       imm_i,
    input  pc_t                        pc_i,
    input  opr_sel_e                   opr1_sel_i,
    input  opr_sel_e                   opr2_sel_i,
    input  logic [`FU_FUNC3_WIDTH-1:0] func3_i,
    input  logic                       is_branch_i,
    input  logic                       is_jump_i,

    output xlen_t                      opr1_o,
    output xlen_t                      opr2_o,
    output alu_func_e                  func_sel_o,
    output logic                       cmp_en_o
);

    xlen_t imm_ext;
    xlen_t pc_ext;

    // immediate is signed while pc is an address
    assign imm_ext = {{(`FU_XLEN-`FU_IMM_LEN){imm_i[`FU_IMM_LEN-1]}}, imm_i};
    assign pc_ext  = {{(`FU_XLEN-`FU_PC_WIDTH){1'b0}}, pc_i};

    always_comb begin
        opr1_o = '0;
        opr2_o = '0;
        if (req_valid_i) begin
            case (opr1_sel_i)
                OPR_SEL_REG: opr1_o = rs1_i;
                // zero base lets lui and csr immediates pass opr2 through
                OPR_SEL_IMM: opr1_o = '0;
                OPR_SEL_PC:  opr1_o = pc_ext;
                default:     opr1_o = '0;
            endcase
            case (opr2_sel_i)
                OPR_SEL_REG: opr2_o = rs2_i;
                OPR_SEL_IMM: opr2_o = imm_ext;
                OPR_SEL_PC:  opr2_o = pc_ext;
                default:     opr2_o = '0;
            endcase
        end
    end

    // branch and jump targets come out of the adder
    assign func_sel_o = is_branch_i ? ALU_ADD_SUB : alu_func_e'(func3_i);

    // only conditional branches use the comparator
    assign cmp_en_o = is_branch_i & ~is_jump_i;

    // rename never hands out the reserved source encoding
    opr_sel_legal: assert final (
        !req_valid_i ||
        ((opr1_sel_i != opr_sel_e'(2'd3)) && (opr2_sel_i != opr_sel_e'(2'd3)))
    ) else $error("illegal operand source on a valid request");

endmodule

//--- logic/fu_alu.sv
`include "fu_consts.svh"

module fu_alu
    import fu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       flush_i,

    input  logic       req_valid_i,
    input  xlen_t      opr1_i,
    input  xlen_t      opr2_i,
    input  alu_func_e  func_sel_i,
    input  logic       func_modifier_i,
    input  logic       half_i,
    input  logic       cmp_en_i,
    input  xlen_t      cmp_a_i,
    input  xlen_t      cmp_b_i,
    input  br_func_e   br_func_i,
    input  logic       is_branch_i,
    input  logic       is_jump_i,
    input  pc_t        next_pc_i,
    input  rob_index_t rob_index_i,
    input  prd_addr_t  prd_addr_i,

    output logic       resp_valid_o,
    output xlen_t      result_o,
    output logic       cmp_taken_o,
    output logic       is_branch_o,
    output logic       is_jump_o,
    output pc_t        next_pc_o,
    output rob_index_t rob_index_o,
    output prd_addr_t  prd_addr_o
);

    localparam int EXT_W = `FU_XLEN - `FU_HALF_XLEN;

    xlen_t                      a_op;
    xlen_t                      b_op;
    xlen_t                      srl_src;
    logic [`FU_SHAMT_WIDTH-1:0] shamt;
    logic                       sub_en;
    xlen_t                      raw_res;
    xlen_t                      alu_res;
    logic                       cmp_res;

    logic       resp_valid_q;
    logic       cmp_taken_q;
    logic       is_branch_q;
    logic       is_jump_q;
    xlen_t      result_q;
    pc_t        next_pc_q;
    rob_index_t rob_index_q;
    prd_addr_t  prd_addr_q;

    // word forms sign-extend both operands so compares and sra stay right
    assign a_op    = half_i ? {{EXT_W{opr1_i[`FU_HALF_XLEN-1]}}, opr1_i[`FU_HALF_XLEN-1:0]}
                            : opr1_i;
    assign b_op    = half_i ? {{EXT_W{opr2_i[`FU_HALF_XLEN-1]}}, opr2_i[`FU_HALF_XLEN-1:0]}
                            : opr2_i;
    // srlw must not pull in sign bits
    assign srl_src = half_i ? {{EXT_W{1'b0}}, opr1_i[`FU_HALF_XLEN-1:0]} : opr1_i;
    assign shamt   = half_i ? {1'b0, opr2_i[`FU_HALF_SHAMT_WIDTH-1:0]}
                            : opr2_i[`FU_SHAMT_WIDTH-1:0];
    // a branch target is always an add
    assign sub_en  = func_modifier_i & ~is_branch_i;

    always_comb begin
        case (func_sel_i)
            ALU_ADD_SUB: raw_res = sub_en ? (a_op - b_op) : (a_op + b_op);
            ALU_SLL:     raw_res = a_op << shamt;
            ALU_SLT:     raw_res = {{(`FU_XLEN-1){1'b0}}, $signed(a_op) < $signed(b_op)};
            ALU_SLTU:    raw_res = {{(`FU_XLEN-1){1'b0}}, a_op < b_op};
            ALU_XOR:     raw_res = a_op ^ b_op;
            ALU_SRL_SRA: begin
                if (func_modifier_i) begin
                    raw_res = $signed(a_op) >>> shamt;
                end else begin
                    raw_res = srl_src >> shamt;
                end
            end
            ALU_OR:      raw_res = a_op | b_op;
            ALU_AND:     raw_res = a_op & b_op;
            default:     raw_res = '0;
        endcase
    end

    assign alu_res = half_i ? {{EXT_W{raw_res[`FU_HALF_XLEN-1]}}, raw_res[`FU_HALF_XLEN-1:0]}
                            : raw_res;

    always_comb begin
        case (br_func_i)
            BR_BEQ:  cmp_res = cmp_a_i == cmp_b_i;
            BR_BNE:  cmp_res = cmp_a_i != cmp_b_i;
            BR_BLT:  cmp_res = $signed(cmp_a_i) < $signed(cmp_b_i);
            BR_BGE:  cmp_res = $signed(cmp_a_i) >= $signed(cmp_b_i);
            BR_BLTU: cmp_res = cmp_a_i < cmp_b_i;
            BR_BGEU: cmp_res = cmp_a_i >= cmp_b_i;
            default: cmp_res = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            resp_valid_q <= 1'b0;
            cmp_taken_q  <= 1'b0;
            is_branch_q  <= 1'b0;
            is_jump_q    <= 1'b0;
        end else begin
            // a flush at the sampling edge kills the request
            resp_valid_q <= req_valid_i & ~flush_i;
            if (req_valid_i) begin
                cmp_taken_q <= cmp_en_i & cmp_res;
                is_branch_q <= is_branch_i;
                is_jump_q   <= is_jump_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            result_q    <= alu_res;
            next_pc_q   <= next_pc_i;
            rob_index_q <= rob_index_i;
            prd_addr_q  <= prd_addr_i;
        end
    end

    assign resp_valid_o = resp_valid_q;
    assign result_o     = result_q;
    assign cmp_taken_o  = cmp_taken_q;
    assign is_branch_o  = is_branch_q;
    assign is_jump_o    = is_jump_q;
    assign next_pc_o    = next_pc_q;
    assign rob_index_o  = rob_index_q;
    assign prd_addr_o   = prd_addr_q;

    // decode marks every jump as a branch too
    jump_is_branch: assert property (@(posedge clk) disable iff (!rst_n_i)
        req_valid_i && is_jump_i |-> is_branch_i);

    no_resp_after_flush: assert property (@(posedge clk) disable iff (!rst_n_i)
        flush_i |=> !resp_valid_o);

endmodule

//--- logic/fu_branch_resolve.sv
`include "fu_consts.svh"

module fu_branch_resolve
    import fu_pkg::*;
(
    input  xlen_t result_i,
    input  logic  cmp_taken_i,
    input  logic  is_branch_i,
    input  logic  is_jump_i,
    input  pc_t   next_pc_i,
    input  pc_t   predict_pc_i,

    output xlen_t wrb_data_o,
    output logic  branch_taken_o,
    output pc_t   final_next_pc_o,
    output logic  branch_predict_miss_o
);

    logic cond_branch;
    logic redirect;
    pc_t  target_pc;
    pc_t  final_next_pc;

    // jumps carry is_branch as well, so mask them out
    assign cond_branch = is_branch_i & ~is_jump_i;

    assign branch_taken_o = cond_branch & cmp_taken_i;

    // the adder output holds the target
    assign target_pc = result_i[`FU_PC_WIDTH-1:0];

    assign redirect = is_jump_i | branch_taken_o;

    always_comb begin
        if (redirect) begin
            final_next_pc = target_pc;
        end else begin
            final_next_pc = next_pc_i;
        end
    end

    assign final_next_pc_o = final_next_pc;

    // jal and jalr write back the return address
    assign wrb_data_o = is_jump_i ? {{(`FU_XLEN-`FU_PC_WIDTH){1'b0}}, next_pc_i} : result_i;

    // any difference from the fetch prediction is a redirect
    assign branch_predict_miss_o = final_next_pc != predict_pc_i;

endmodule

//--- logic/fu_exec.sv
module fu_exec
    import fu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,

    input  logic       req_valid_i,
    input  xlen_t      rs1_i,
    input  xlen_t      rs2_i,
    input  imm_t       imm_i,
    input  opr_sel_e   opr1_sel_i,
    input  opr_sel_e   opr2_sel_i,
    input  logic [2:0] func3_i,
    input  logic       func_modifier_i,
    input  logic       half_i,
    input  logic       is_branch_i,
    input  logic       is_jump_i,
    input  pc_t        pc_i,
    input  pc_t        next_pc_i,
    input  pc_t        predict_pc_i,
    input  rob_index_t rob_index_i,
    input  prd_addr_t  prd_addr_i,
    input  logic       global_trap_i,
    input  logic       global_ret_i,
    input  logic       global_predict_miss_i,

    output logic       resp_valid_o,
    output rob_index_t wrb_rob_index_o,
    output prd_addr_t  wrb_prd_addr_o,
    output xlen_t      wrb_data_o,
    output logic       branch_taken_o,
    output logic       branch_predict_miss_o,
    output pc_t        final_next_pc_o
);

    logic      flush;
    xlen_t     opr1;
    xlen_t     opr2;
    alu_func_e func_sel;
    logic      cmp_en;
    xlen_t     alu_result;
    logic      alu_cmp_taken;
    logic      alu_is_branch;
    logic      alu_is_jump;
    pc_t       alu_next_pc;
    pc_t       predict_pc_q;

    // trap, return or mispredict all kill the lane
    assign flush = global_trap_i | global_ret_i | global_predict_miss_i;

    fu_opr_select u_opr_select (
        .req_valid_i (req_valid_i),
        .rs1_i       (rs1_i),
        .rs2_i       (rs2_i),
        .imm_i       (imm_i),
        .pc_i        (pc_i),
        .opr1_sel_i  (opr1_sel_i),
        .opr2_sel_i  (opr2_sel_i),
        .func3_i     (func3_i),
        .is_branch_i (is_branch_i),
        .is_jump_i   (is_jump_i),
        .opr1_o      (opr1),
        .opr2_o      (opr2),
        .func_sel_o  (func_sel),
        .cmp_en_o    (cmp_en)
    );

    fu_alu u_alu (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .flush_i         (flush),
        .req_valid_i     (req_valid_i),
        .opr1_i          (opr1),
        .opr2_i          (opr2),
        .func_sel_i      (func_sel),
        .func_modifier_i (func_modifier_i),
        .half_i          (half_i),
        .cmp_en_i        (cmp_en),
        .cmp_a_i         (rs1_i),
        .cmp_b_i         (rs2_i),
        .br_func_i       (br_func_e'(func3_i)),
        .is_branch_i     (is_branch_i),
        .is_jump_i       (is_jump_i),
        .next_pc_i       (next_pc_i),
        .rob_index_i     (rob_index_i),
        .prd_addr_i      (prd_addr_i),
        .resp_valid_o    (resp_valid_o),
        .result_o        (alu_result),
        .cmp_taken_o     (alu_cmp_taken),
        .is_branch_o     (alu_is_branch),
        .is_jump_o       (alu_is_jump),
        .next_pc_o       (alu_next_pc),
        .rob_index_o     (wrb_rob_index_o),
        .prd_addr_o      (wrb_prd_addr_o)
    );

    // prediction travels beside the alu stage to meet its result
    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            predict_pc_q <= predict_pc_i;
        end
    end

    fu_branch_resolve u_branch_resolve (
        .result_i              (alu_result),
        .cmp_taken_i           (alu_cmp_taken),
        .is_branch_i           (alu_is_branch),
        .is_jump_i             (alu_is_jump),
        .next_pc_i             (alu_next_pc),
        .predict_pc_i          (predict_pc_q),
        .wrb_data_o            (wrb_data_o),
        .branch_taken_o        (branch_taken_o),
        .final_next_pc_o       (final_next_pc_o),
        .branch_predict_miss_o (branch_predict_miss_o)
    );

endmodule

//--- test/tb_fu_exec.sv
`include "fu_consts.svh"

module tb_fu_exec
    import fu_pkg::*;
();

    localparam int NUM_REQS       = 114;
    localparam int TIMEOUT_CYCLES = 16 + 2 * NUM_REQS + 50;
    localparam int HW             = `FU_HALF_XLEN;

    logic       clk;
    logic       rst_n_i;
    logic       req_valid_i;
    xlen_t      rs1_i;
    xlen_t      rs2_i;
    imm_t       imm_i;
    opr_sel_e   opr1_sel_i;
    opr_sel_e   opr2_sel_i;
    logic [2:0] func3_i;
    logic       func_modifier_i;
    logic       half_i;
    logic       is_branch_i;
    logic       is_jump_i;
    pc_t        pc_i;
    pc_t        next_pc_i;
    pc_t        predict_pc_i;
    rob_index_t rob_index_i;
    prd_addr_t  prd_addr_i;
    logic       global_trap_i;
    logic       global_ret_i;
    logic       global_predict_miss_i;

    logic       resp_valid_o;
    rob_index_t wrb_rob_index_o;
    prd_addr_t  wrb_prd_addr_o;
    xlen_t      wrb_data_o;
    logic       branch_taken_o;
    logic       branch_predict_miss_o;
    pc_t        final_next_pc_o;

    logic [15:0] lfsr_state;
    int          mismatch_cnt;
    int          other_cnt;
    int          cycle_cnt = 0;

    // expected responses in issue order
    xlen_t      exp_data_q[$];
    logic       exp_taken_q[$];
    pc_t        exp_npc_q[$];
    logic       exp_miss_q[$];
    rob_index_t exp_rob_q[$];
    prd_addr_t  exp_prd_q[$];

    fu_exec dut0 (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic xlen_t rand_bits(input int n);
        xlen_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[`FU_XLEN-2:0], lfsr_bit()};
        end
        return r;
    endfunction

    function automatic pc_t rand_pc();
        xlen_t r;
        r = rand_bits(30);
        return {r[29:0], 2'b00};
    endfunction

    function automatic imm_t rand_imm12();
        xlen_t r;
        r = rand_bits(12);
        return {{20{r[11]}}, r[11:0]};
    endfunction

    function automatic xlen_t sext_imm(input imm_t imm);
        return {{(`FU_XLEN-`FU_IMM_LEN){imm[`FU_IMM_LEN-1]}}, imm};
    endfunction

    function automatic xlen_t zext_pc(input pc_t pc);
        return {{(`FU_XLEN-`FU_PC_WIDTH){1'b0}}, pc};
    endfunction

    // riscv integer semantics with word forms on the low half
    function automatic xlen_t model_alu(input xlen_t a, input xlen_t b, input logic [2:0] f3,
                                        input logic mod, input logic half);
        logic [HW-1:0] aw;
        logic [HW-1:0] bw;
        logic [HW-1:0] sra_w;
        logic [HW-1:0] rw;
        xlen_t         sra_d;
        xlen_t         r;
        aw    = a[HW-1:0];
        bw    = b[HW-1:0];
        sra_w = $signed(aw) >>> bw[4:0];
        sra_d = $signed(a) >>> b[5:0];
        if (half) begin
            case (f3)
                3'd0:    rw = mod ? aw - bw : aw + bw;
                3'd1:    rw = aw << bw[4:0];
                3'd2:    rw = ($signed(aw) < $signed(bw)) ? 1 : 0;
                3'd3:    rw = (aw < bw) ? 1 : 0;
                3'd4:    rw = aw ^ bw;
                3'd5:    rw = mod ? sra_w : aw >> bw[4:0];
                3'd6:    rw = aw | bw;
                default: rw = aw & bw;
            endcase
            r = {{(`FU_XLEN-HW){rw[HW-1]}}, rw};
        end else begin
            case (f3)
                3'd0:    r = mod ? a - b : a + b;
                3'd1:    r = a << b[5:0];
                3'd2:    r = ($signed(a) < $signed(b)) ? 1 : 0;
                3'd3:    r = (a < b) ? 1 : 0;
                3'd4:    r = a ^ b;
                3'd5:    r = mod ? sra_d : a >> b[5:0];
                3'd6:    r = a | b;
                default: r = a & b;
            endcase
        end
        return r;
    endfunction

    function automatic logic model_cmp(input logic [2:0] f3, input xlen_t a, input xlen_t b);
        case (f3)
            BR_BEQ:  return a == b;
            BR_BNE:  return a != b;
            BR_BLT:  return $signed(a) < $signed(b);
            BR_BGE:  return $signed(a) >= $signed(b);
            BR_BLTU: return a < b;
            BR_BGEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic check_xlen(input string name, input xlen_t exp, input xlen_t act);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic check_pc(input string name, input pc_t exp, input pc_t act);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic check_tag(input string name, input prd_addr_t exp, input prd_addr_t act);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic idle_inputs();
        req_valid_i           = 1'b0;
        rs1_i                 = '0;
        rs2_i                 = '0;
        imm_i                 = '0;
        opr1_sel_i            = OPR_SEL_REG;
        opr2_sel_i            = OPR_SEL_REG;
        func3_i               = '0;
        func_modifier_i       = 1'b0;
        half_i                = 1'b0;
        is_branch_i           = 1'b0;
        is_jump_i             = 1'b0;
        pc_i                  = '0;
        next_pc_i             = '0;
        predict_pc_i          = '0;
        rob_index_i           = '0;
        prd_addr_i            = '0;
        global_trap_i         = 1'b0;
        global_ret_i          = 1'b0;
        global_predict_miss_i = 1'b0;
    endtask

    // drives one request and queues its expected response unless flushed
    task automatic drive_req(input xlen_t rs1, input xlen_t rs2, input imm_t imm,
                             input opr_sel_e s1, input opr_sel_e s2, input logic [2:0] f3,
                             input logic mod, input logic half, input logic br,
                             input logic jmp, input pc_t pc, input logic predict_ok);
        xlen_t      op1;
        xlen_t      op2;
        xlen_t      res;
        xlen_t      tags;
        logic       taken;
        pc_t        npc;
        pc_t        fnpc;
        rob_index_t rob;
        prd_addr_t  prd;
        npc  = pc + 4;
        tags = rand_bits(10);
        rob  = tags[9:6];
        prd  = tags[5:0];
        op1  = (s1 == OPR_SEL_REG) ? rs1 : (s1 == OPR_SEL_PC) ? zext_pc(pc) : '0;
        op2  = (s2 == OPR_SEL_REG) ? rs2 : (s2 == OPR_SEL_PC) ? zext_pc(pc) : sext_imm(imm);
        // targets always come from an add
        res   = br ? model_alu(op1, op2, 3'd0, 1'b0, half) : model_alu(op1, op2, f3, mod, half);
        taken = br & ~jmp & model_cmp(f3, rs1, rs2);
        fnpc  = (jmp | taken) ? res[`FU_PC_WIDTH-1:0] : npc;

        req_valid_i     = 1'b1;
        rs1_i           = rs1;
        rs2_i           = rs2;
        imm_i           = imm;
        opr1_sel_i      = s1;
        opr2_sel_i      = s2;
        func3_i         = f3;
        func_modifier_i = mod;
        half_i          = half;
        is_branch_i     = br;
        is_jump_i       = jmp;
        pc_i            = pc;
        next_pc_i       = npc;
        predict_pc_i    = predict_ok ? fnpc : fnpc + 8;
        rob_index_i     = rob;
        prd_addr_i      = prd;

        if (!(global_trap_i | global_ret_i | global_predict_miss_i)) begin
            exp_data_q.push_back(jmp ? zext_pc(npc) : res);
            exp_taken_q.push_back(taken);
            exp_npc_q.push_back(fnpc);
            exp_miss_q.push_back(fnpc != predict_pc_i);
            exp_rob_q.push_back(rob);
            exp_prd_q.push_back(prd);
        end
    endtask

    task automatic check_resp();
        if (exp_data_q.size() == 0) begin
            $display("error at %0t: a response was checked with no request outstanding", $time);
            other_cnt++;
        end else begin
            check_bit("resp_valid_o", 1'b1, resp_valid_o);
            check_xlen("wrb_data_o", exp_data_q.pop_front(), wrb_data_o);
            check_bit("branch_taken_o", exp_taken_q.pop_front(), branch_taken_o);
            check_pc("final_next_pc_o", exp_npc_q.pop_front(), final_next_pc_o);
            check_bit("branch_predict_miss_o", exp_miss_q.pop_front(), branch_predict_miss_o);
            check_tag("wrb_rob_index_o", prd_addr_t'(exp_rob_q.pop_front()),
                      prd_addr_t'(wrb_rob_index_o));
            check_tag("wrb_prd_addr_o", exp_prd_q.pop_front(), wrb_prd_addr_o);
        end
    endtask

    // response belongs to the cycle right after the sampling edge
    task automatic collect_resp();
        @(negedge clk);
        check_resp();
        idle_inputs();
    endtask

    task automatic run_alu(input xlen_t a, input xlen_t b, input imm_t imm, input opr_sel_e s2,
                           input logic [2:0] f3, input logic mod, input logic half);
        drive_req(a, b, imm, OPR_SEL_REG, s2, f3, mod, half, 1'b0, 1'b0, rand_pc(), 1'b1);
        collect_resp();
    endtask

    task automatic issue_rand();
        xlen_t a;
        xlen_t b;
        xlen_t f;
        a = rand_bits(64);
        b = rand_bits(64);
        f = rand_bits(3);
        drive_req(a, b, '0, OPR_SEL_REG, OPR_SEL_REG, f[2:0], 1'b0, 1'b0, 1'b0, 1'b0,
                  rand_pc(), 1'b1);
    endtask

    task automatic reset_test();
        rst_n_i = 1'b0;
        repeat (16) begin
            @(negedge clk);
            check_bit("resp_valid_o", 1'b0, resp_valid_o);
        end
        rst_n_i = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_bit("resp_valid_o", 1'b0, resp_valid_o);
        end
    endtask

    task automatic arith_test();
        xlen_t a;
        xlen_t b;
        imm_t  imm;
        for (int round = 0; round < 2; round++) begin
            a   = rand_bits(64);
            b   = rand_bits(64);
            imm = rand_imm12();
            // second round makes both halves negative for the shifts
            if (round == 1) begin
                a = a | 64'h8000_0000_8000_0000;
            end
            for (int f = 0; f < 8; f++) begin
                run_alu(a, b, imm, OPR_SEL_REG, 3'(f), 1'b0, 1'b0);
                run_alu(a, b, imm, OPR_SEL_IMM, 3'(f), 1'b0, 1'b0);
            end
            run_alu(a, b, imm, OPR_SEL_REG, ALU_ADD_SUB, 1'b1, 1'b0);
            run_alu(a, b, imm, OPR_SEL_REG, ALU_SRL_SRA, 1'b1, 1'b0);
            run_alu(a, b, imm, OPR_SEL_IMM, ALU_SRL_SRA, 1'b1, 1'b0);
            // addw subw sllw srlw sraw addiw
            run_alu(a, b, imm, OPR_SEL_REG, ALU_ADD_SUB, 1'b0, 1'b1);
            run_alu(a, b, imm, OPR_SEL_REG, ALU_ADD_SUB, 1'b1, 1'b1);
            run_alu(a, b, imm, OPR_SEL_REG, ALU_SLL, 1'b0, 1'b1);
            run_alu(a, b, imm, OPR_SEL_REG, ALU_SRL_SRA, 1'b0, 1'b1);
            run_alu(a, b, imm, OPR_SEL_REG, ALU_SRL_SRA, 1'b1, 1'b1);
            run_alu(a, b, imm, OPR_SEL_IMM, ALU_ADD_SUB, 1'b0, 1'b1);
        end
    endtask

    task automatic operand_src_test();
        xlen_t r;
        xlen_t a;
        imm_t  up;
        r  = rand_bits(20);
        a  = rand_bits(64);
        up = {r[19:0], 12'h000};
        for (int i = 0; i < 2; i++) begin
            // lui then auipc with each sign of the upper immediate
            drive_req(a, a, up, OPR_SEL_IMM, OPR_SEL_IMM, ALU_ADD_SUB, 1'b0, 1'b0, 1'b0,
                      1'b0, rand_pc(), 1'b1);
            collect_resp();
            drive_req(a, a, up, OPR_SEL_PC, OPR_SEL_IMM, ALU_ADD_SUB, 1'b0, 1'b0, 1'b0,
                      1'b0, rand_pc(), 1'b1);
            collect_resp();
            up[31] = ~up[31];
        end
    endtask

    task automatic branch_test();
        xlen_t      a[4];
        xlen_t      b[4];
        logic [2:0] conds[6];
        xlen_t      base;
        base  = rand_bits(32);
        a[0]  = base;
        b[0]  = base;
        a[1]  = base;
        b[1]  = base + 1;
        a[2]  = base + 1;
        b[2]  = base;
        // less when signed but greater when unsigned
        a[3]  = 64'hFFFF_FFFF_FFFF_FFFB;
        b[3]  = 64'd3;
        conds = '{BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};
        foreach (conds[c]) begin
            for (int p = 0; p < 4; p++) begin
                for (int ok = 1; ok >= 0; ok--) begin
                    drive_req(a[p], b[p], {rand_imm12()} << 1, OPR_SEL_PC, OPR_SEL_IMM,
                              conds[c], 1'b0, 1'b0, 1'b1, 1'b0, rand_pc(), ok != 0);
                    collect_resp();
                end
            end
        end
    endtask

    task automatic jump_test();
        xlen_t base;
        imm_t  off;
        base = rand_bits(64);
        off  = rand_imm12();
        for (int ok = 1; ok >= 0; ok--) begin
            // jal
            drive_req(base, base, off, OPR_SEL_PC, OPR_SEL_IMM, 3'd0, 1'b0, 1'b0, 1'b1, 1'b1,
                      rand_pc(), ok != 0);
            collect_resp();
            // jalr
            drive_req(base, base, off, OPR_SEL_REG, OPR_SEL_IMM, 3'd0, 1'b0, 1'b0, 1'b1, 1'b1,
                      rand_pc(), ok != 0);
            collect_resp();
        end
    endtask

    task automatic flush_test();
        // four back to back with each answered while the next is issued
        issue_rand();
        repeat (3) begin
            @(negedge clk);
            check_resp();
            issue_rand();
        end
        @(negedge clk);
        check_resp();
        idle_inputs();

        global_trap_i = 1'b1;
        issue_rand();
        @(negedge clk);
        check_bit("resp_valid_o", 1'b0, resp_valid_o);
        idle_inputs();
        global_ret_i = 1'b1;
        issue_rand();
        @(negedge clk);
        check_bit("resp_valid_o", 1'b0, resp_valid_o);
        idle_inputs();
        global_predict_miss_i = 1'b1;
        issue_rand();
        @(negedge clk);
        check_bit("resp_valid_o", 1'b0, resp_valid_o);
        idle_inputs();
        issue_rand();
        collect_resp();
    endtask

    initial begin
        clk          = 1'b0;
        rst_n_i      = 1'b0;
        lfsr_state   = 16'd46;
        mismatch_cnt = 0;
        other_cnt    = 0;
        idle_inputs();

        reset_test();
        arith_test();
        operand_src_test();
        branch_test();
        jump_test();
        flush_test();

        @(negedge clk);
        check_bit("resp_valid_o", 1'b0, resp_valid_o);
        if (exp_data_q.size() != 0) begin
            $display("error: %0d expected responses never arrived", exp_data_q.size());
            other_cnt++;
        end
        $display("errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+logic
logic/fu_pkg.sv
logic/fu_opr_select.sv
logic/fu_alu.sv
logic/fu_branch_resolve.sv
logic/fu_exec.sv
test/tb_fu_exec.sv

//--- Bender.yml
package:
  name: fu_exec

sources:
  - include_dirs:
      - logic
    files:
      - logic/fu_pkg.sv
      - logic/fu_opr_select.sv
      - logic/fu_alu.sv
      - logic/fu_branch_resolve.sv
      - logic/fu_exec.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/tb_fu_exec.sv
